// ==== build.f ====
+incdir+source
source/mips_pkg.sv
source/instr_decoder.sv
source/control_fsm.sv
source/alu.sv
source/reg_file.sv
source/datapath.sv
source/mips_core.sv
testbench/mips_core_sva.sv
testbench/mips_core_tb.sv

// ==== Bender.yml ====
package:
  name: mips_core

export_include_dirs:
  - source

sources:
  - files:
      - source/mips_pkg.sv
      - source/instr_decoder.sv
      - source/control_fsm.sv
      - source/alu.sv
      - source/reg_file.sv
      - source/datapath.sv
      - source/mips_core.sv
  - target: simulation
    files:
      - testbench/mips_core_sva.sv
      - testbench/mips_core_tb.sv

// ==== testbench/mips_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_core_tb;
  import mips_pkg::*;

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 10;
  localparam int MEM_WORDS    = 256;  // 1 KiB
  localparam logic [5:0] ALU_FUNCTS [7] = '{6'h21, 6'h23, 6'h2b, 6'h24, 6'h25, 6'h26, 6'h27};
  localparam logic [5:0] IMM_OPS [6] = '{6'h09, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [`MIPS_XLEN-1:0] mem_rdata;
  mem_req_t              mem_req;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] prog [$];
  logic [31:0] preset_addr [$];
  logic [31:0] preset_data [$];
  logic [31:0] dut_reads [$];
  logic [31:0] ref_reads [$];
  mem_req_t    dut_stores [$];
  mem_req_t    ref_stores [$];
  logic [31:0] halt_addr = '0;
  logic        logging = 1'b0;
  logic        halted = 1'b0;
  logic [31:0] rng_state = 32'd85;
  int unsigned errors = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  int unsigned cycle_count = 0;
  int unsigned budget_cycles = 50;

  mips_core mips_core_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata)
  );

  always #HALF_PERIOD clk = ~clk;

  // Memory model plus port monitor
  always @(posedge clk)
  begin
    if (mem_req.read)
    begin
      mem_rdata <= mem[mem_req.addr[9:2]];
    end
    if (mem_req.write)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (mem_req.be[b])
        begin
          mem[mem_req.addr[9:2]][8*b +: 8] <= mem_req.wdata[8*b +: 8];
        end
      end
    end
    if (logging && mem_req.write)
    begin
      dut_stores.push_back(mem_req);
    end
    if (logging && mem_req.read)
    begin
      dut_reads.push_back(mem_req.addr);
      if (mem_req.addr == halt_addr)
      begin
        logging = 1'b0;
        halted  = 1'b1;
      end
    end
  end

  // Budget grows with each program's reference length
  initial
  begin
    while (cycle_count <= budget_cycles)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the core did not reach the end of a program within %0d cycles",
             budget_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic int unsigned leading_count(input logic [31:0] v, input logic ones);
    int unsigned n;
    n = 0;
    while (n < 32 && v[31-n] == ones)
    begin
      n++;
    end
    return n;
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic load_const(input logic [4:0] r, input logic [31:0] v);
    emit(i_type(6'h0f, 5'd0, r, v[31:16]));  // LUI
    emit(i_type(6'h0d, r, r, v[15:0]));      // ORI
  endtask

  task automatic store_result(input logic [4:0] rt, input logic [15:0] off);
    emit(i_type(6'h2b, 5'd1, rt, off));  // SW rt, off($1)
  endtask

  task automatic begin_program();
    emit(i_type(6'h09, 5'd0, 5'd1, 16'h0200));  // Store base in $1
  endtask

  task automatic preset(input logic [31:0] addr, input logic [31:0] data);
    preset_addr.push_back(addr);
    preset_data.push_back(data);
  endtask

  task automatic check_word(input string what, input logic [`MIPS_XLEN-1:0] got,
                            input logic [`MIPS_XLEN-1:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_req(input string what, input mem_req_t got, input mem_req_t exp);
    logic [31:0] mask;
    mask = '0;
    for (int k = 0; k < 4; k++)
    begin
      mask[8*k +: 8] = {8{exp.be[k]}};  // Only enabled lanes carry data
    end
    if (got.addr !== exp.addr || got.be !== exp.be || (got.wdata & mask) !== (exp.wdata & mask))
    begin
      errors++;
      $display("Error at %0t ns: %s addr %08h be %b data %08h, expected %08h %b %08h", $time,
               what, got.addr, got.be, got.wdata & mask, exp.addr, exp.be, exp.wdata & mask);
    end
  endtask

  // Instruction-level model of the supported subset
  task automatic reference_run(input logic [31:0] halt_pc, output int unsigned n_instr);
    logic [31:0] regs [`MIPS_NREGS];
    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] zimm;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] res;
    logic [3:0]  be;
    logic [4:0]  dst;
    logic        wr;
    mem_req_t    req;
    foreach (regs[i])
    begin
      regs[i] = '0;
    end
    ref_reads.delete();
    ref_stores.delete();
    pc      = `MIPS_RESET_PC;
    n_instr = 0;
    while (n_instr < 5000)
    begin
      ref_reads.push_back(pc);
      if (pc == halt_pc)
      begin
        break;
      end
      ir   = ref_mem[pc[9:2]];
      a    = regs[ir[25:21]];
      b    = regs[ir[20:16]];
      simm = {{16{ir[15]}}, ir[15:0]};
      zimm = {16'h0000, ir[15:0]};
      addr = a + simm;
      pc   = pc + 32'd4;
      wr   = 1'b1;
      dst  = ir[20:16];
      res  = '0;
      n_instr++;
      case (ir[31:26])
        6'h00:
        begin
          dst = ir[15:11];
          case (ir[5:0])
            6'h21: res = a + b;
            6'h23: res = a - b;
            6'h2b: res = (a < b) ? 32'd1 : 32'd0;
            6'h24: res = a & b;
            6'h25: res = a | b;
            6'h26: res = a ^ b;
            6'h27: res = ~(a | b);
            6'h00: res = b << ir[10:6];
            6'h03: res = $signed(b) >>> ir[10:6];
            6'h02: res = b >> ir[10:6];
            default: wr = 1'b0;
          endcase
        end
        6'h1c:
        begin
          dst = ir[15:11];
          wr  = (ir[5:0] == 6'h21) || (ir[5:0] == 6'h20);
          res = leading_count(a, ir[0]);  // CLO counts ones
        end
        6'h09: res = a + simm;
        6'h0b: res = (a < simm) ? 32'd1 : 32'd0;
        6'h0c: res = a & zimm;
        6'h0d: res = a | zimm;
        6'h0e: res = a ^ zimm;
        6'h0f: res = zimm << 16;
        6'h04:
        begin
          wr = 1'b0;
          if (a == b)
          begin
            pc = pc + (simm << 2);
          end
        end
        6'h28, 6'h29, 6'h2b:
        begin
          wr = 1'b0;
          if (ir[31:26] == 6'h28)
          begin
            be   = 4'b0001 << addr[1:0];
            word = {24'h000000, b[7:0]} << (8 * addr[1:0]);
          end
          else if (ir[31:26] == 6'h29)
          begin
            be   = addr[1] ? 4'b1100 : 4'b0011;
            word = {16'h0000, b[15:0]} << (16 * addr[1]);
          end
          else
          begin
            be   = 4'b1111;
            word = b;
          end
          req       = '0;
          req.write = 1'b1;
          req.addr  = addr;
          req.wdata = word;
          req.be    = be;
          ref_stores.push_back(req);
          for (int k = 0; k < 4; k++)
          begin
            if (be[k])
            begin
              ref_mem[addr[9:2]][8*k +: 8] = word[8*k +: 8];
            end
          end
        end
        6'h20, 6'h24, 6'h21, 6'h25, 6'h23:
        begin
          ref_reads.push_back(addr);
          word = ref_mem[addr[9:2]] >> (8 * addr[1:0]);
          case (ir[31:26])
            6'h20: res = {{24{word[7]}}, word[7:0]};
            6'h24: res = {24'h000000, word[7:0]};
            6'h21: res = {{16{word[15]}}, word[15:0]};
            6'h25: res = {16'h0000, word[15:0]};
            default: res = ref_mem[addr[9:2]];
          endcase
        end
        default: wr = 1'b0;  // Not implemented, no effect
      endcase
      if (wr && dst != 5'd0)
      begin
        regs[dst] = res;
      end
    end
  endtask

  task automatic run_program(input string name);
    logic [31:0]  halt_pc;
    int unsigned  n_instr;
    int unsigned  err_before;
    int unsigned  n_reads;
    int unsigned  n_stores;
    err_before = errors;
    halt_pc    = `MIPS_RESET_PC + 32'(4 * prog.size());
    emit(i_type(6'h04, 5'd0, 5'd0, 16'hffff));  // Branch to itself
    @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem[i] = (i + 1) * 32'h9e37_79b9;
    end
    foreach (prog[i])
    begin
      mem[(`MIPS_RESET_PC >> 2) + i] = prog[i];
    end
    foreach (preset_addr[i])
    begin
      mem[preset_addr[i][9:2]] = preset_data[i];
    end
    ref_mem = mem;
    reference_run(halt_pc, n_instr);
    budget_cycles = cycle_count + RESET_CYCLES + 6 * n_instr + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    dut_reads.delete();
    dut_stores.delete();
    halt_addr = halt_pc;
    halted    = 1'b0;
    logging   = 1'b1;
    rst_n    <= 1'b1;
    wait (halted);
    n_reads  = (dut_reads.size() < ref_reads.size()) ? dut_reads.size() : ref_reads.size();
    n_stores = (dut_stores.size() < ref_stores.size()) ? dut_stores.size() : ref_stores.size();
    if (dut_reads.size() != ref_reads.size() || dut_stores.size() != ref_stores.size())
    begin
      errors++;
      $display("Error at %0t ns: %s made %0d reads and %0d writes, expected %0d and %0d",
               $time, name, dut_reads.size(), dut_stores.size(), ref_reads.size(),
               ref_stores.size());
    end
    for (int i = 0; i < n_reads; i++)
    begin
      check_word($sformatf("%s read %0d address", name, i), dut_reads[i], ref_reads[i]);
    end
    for (int i = 0; i < n_stores; i++)
    begin
      check_req($sformatf("%s write %0d", name, i), dut_stores[i], ref_stores[i]);
    end
    tests_run++;
    if (errors != err_before)
    begin
      tests_failed++;
    end
    $display("Test %-14s %0d instructions, %0d errors", name, n_instr, errors - err_before);
    prog.delete();
    preset_addr.delete();
    preset_data.delete();
  endtask

  task automatic test_alu_ops();
    logic [31:0] r;
    logic [15:0] off;
    begin_program();
    off = '0;
    repeat (2)
    begin
      load_const(5'd2, next_rand());
      load_const(5'd3, next_rand());
      foreach (ALU_FUNCTS[i])
      begin
        emit(r_type(ALU_FUNCTS[i], 5'd2, 5'd3, 5'd4, 5'd0));
        store_result(5'd4, off);
        off += 16'd4;
      end
      foreach (IMM_OPS[i])
      begin
        r = next_rand();
        emit(i_type(IMM_OPS[i], (IMM_OPS[i] == 6'h0f) ? 5'd0 : 5'd2, 5'd4, r[15:0]));
        store_result(5'd4, off);
        off += 16'd4;
      end
    end
    run_program("alu_ops");
  endtask

  task automatic test_shift_count();
    logic [31:0] vals [6];
    logic [31:0] r;
    logic [15:0] off;
    vals[0] = 32'h0000_0000;
    vals[1] = 32'hffff_ffff;
    vals[2] = 32'h8000_0000;
    vals[3] = 32'h0000_ffff;
    vals[4] = next_rand();
    vals[5] = next_rand();
    begin_program();
    off = '0;
    foreach (vals[v])
    begin
      r = next_rand();
      load_const(5'd2, vals[v]);
      emit(r_type(6'h00, 5'd0, 5'd2, 5'd4, r[4:0]));    // SLL
      store_result(5'd4, off);
      emit(r_type(6'h03, 5'd0, 5'd2, 5'd4, r[9:5]));    // SRA
      store_result(5'd4, off + 16'd4);
      emit(r_type(6'h02, 5'd0, 5'd2, 5'd4, r[14:10]));  // SRL
      store_result(5'd4, off + 16'd8);
      emit({6'h1c, 5'd2, 5'd4, 5'd4, 5'd0, 6'h21});     // CLO
      store_result(5'd4, off + 16'd12);
      emit({6'h1c, 5'd2, 5'd4, 5'd4, 5'd0, 6'h20});     // CLZ
      store_result(5'd4, off + 16'd16);
      off += 16'd20;
    end
    run_program("shift_count");
  endtask

  task automatic test_stores();
    logic [15:0] base;
    base = '0;
    begin_program();
    repeat (2)
    begin
      load_const(5'd2, next_rand());
      for (int k = 0; k < 4; k++)
      begin
        emit(i_type(6'h28, 5'd1, 5'd2, base + 16'(k)));  // SB
      end
      emit(i_type(6'h29, 5'd1, 5'd2, base + 16'd4));     // SH low half
      emit(i_type(6'h29, 5'd1, 5'd2, base + 16'd6));     // SH high half
      store_result(5'd2, base + 16'd8);
      base += 16'd16;
    end
    run_program("stores");
  endtask

  task automatic test_loads();
    logic [15:0] off;
    logic [15:0] src;
    preset(32'h300, 32'h80ff_7f01);
    preset(32'h304, 32'h7f01_80fe);
    preset(32'h308, next_rand());
    begin_program();
    emit(i_type(6'h09, 5'd0, 5'd5, 16'h0300));
    off = '0;
    for (int w = 0; w < 3; w++)
    begin
      for (int k = 0; k < 4; k++)
      begin
        src = 16'(4 * w + k);
        emit(i_type(6'h20, 5'd5, 5'd4, src));  // LB
        store_result(5'd4, off);
        emit(i_type(6'h24, 5'd5, 5'd4, src));  // LBU
        store_result(5'd4, off + 16'd4);
        if (k[0] == 1'b0)
        begin
          emit(i_type(6'h21, 5'd5, 5'd4, src));  // LH
          store_result(5'd4, off + 16'd8);
          emit(i_type(6'h25, 5'd5, 5'd4, src));  // LHU
          store_result(5'd4, off + 16'd12);
        end
        off += 16'd16;
      end
      emit(i_type(6'h23, 5'd5, 5'd4, 16'(4 * w)));  // LW
      store_result(5'd4, off);
      off += 16'd4;
    end
    run_program("loads");
  endtask

  task automatic test_branch();
    begin_program();
    emit(i_type(6'h09, 5'd0, 5'd2, 16'd5));
    emit(i_type(6'h09, 5'd0, 5'd3, 16'd5));
    emit(i_type(6'h09, 5'd0, 5'd6, 16'd7));
    emit(i_type(6'h09, 5'd0, 5'd7, 16'd3));
    emit(i_type(6'h04, 5'd2, 5'd3, 16'd2));  // Taken, skips two
    emit(i_type(6'h09, 5'd0, 5'd4, 16'h11));
    store_result(5'd4, 16'd0);
    emit(i_type(6'h09, 5'd0, 5'd4, 16'h22));
    store_result(5'd4, 16'd4);
    emit(i_type(6'h04, 5'd2, 5'd6, 16'd1));  // Not taken
    emit(i_type(6'h09, 5'd0, 5'd4, 16'h33));
    store_result(5'd4, 16'd8);
    emit(i_type(6'h09, 5'd7, 5'd7, 16'hffff));  // Countdown loop
    store_result(5'd7, 16'd12);
    emit(i_type(6'h04, 5'd7, 5'd0, 16'd1));
    emit(i_type(6'h04, 5'd0, 5'd0, 16'hfffc));  // Back to loop head
    store_result(5'd6, 16'd16);
    run_program("branch");
  endtask

  task automatic test_illegal();
    begin_program();
    emit(i_type(6'h09, 5'd0, 5'd2, 16'h55));
    emit(i_type(6'h09, 5'd0, 5'd3, 16'h66));
    emit(i_type(6'h09, 5'd0, 5'd4, 16'h77));
    emit(r_type(6'h20, 5'd2, 5'd3, 5'd4, 5'd0));  // ADD
    store_result(5'd4, 16'd0);
    emit({6'h02, 26'd0});                          // J to reset PC
    store_result(5'd4, 16'd4);
    emit({6'h03, 26'd40});                         // JAL
    store_result(5'd2, 16'd8);
    run_program("illegal");
  endtask

  initial
  begin
    rst_n     = 1'b0;
    mem_rdata = '0;
    test_alu_ops();
    test_shift_count();
    test_stores();
    test_loads();
    test_branch();
    test_illegal();
    if (mips_core_i.control_fsm_i.mips_core_sva_i.sva_errors != 0)
    begin
      errors += mips_core_i.control_fsm_i.mips_core_sva_i.sva_errors;
      $display("Assertion failures during the run: %0d",
               mips_core_i.control_fsm_i.mips_core_sva_i.sva_errors);
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/mips_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core_sva (
  input wire clk,
  input wire rst_n,
  input wire mem_read,
  input wire mem_write
);

  int unsigned sva_errors = 0;

  strobes_idle_in_reset: assert property (@(posedge clk) !rst_n |=> (!mem_read && !mem_write))
    else
    begin
      sva_errors++;
      $error("memory strobe active while in reset");
    end

  strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_read && mem_write))
    else
    begin
      sva_errors++;
      $error("read and write strobes high together");
    end

  write_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    mem_write |=> !mem_write)
    else
    begin
      sva_errors++;
      $error("write pulse longer than one cycle");
    end

  fetch_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> mem_read)
    else
    begin
      sva_errors++;
      $error("no fetch read in the cycle after reset release");
    end

endmodule

bind control_fsm mips_core_sva mips_core_sva_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .mem_read  (mem_read),
  .mem_write (mem_write)
);

`default_nettype wire

// ==== source/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_core (
  input  wire                  clk,
  input  wire                  rst_n,
  output mips_pkg::mem_req_t   mem_req,
  input  wire [`MIPS_XLEN-1:0] mem_rdata
);
  import mips_pkg::*;

  logic [`MIPS_XLEN-1:0] instruction;
  state_sel_t            state_sel;
  ctrl_t                 ctrl;
  logic                  br_taken;
  logic                  mem_read;
  logic                  mem_write;

  instr_decoder instr_decoder_i (
    .instruction (instruction),
    .state_sel   (state_sel)
  );

  control_fsm control_fsm_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .state_sel (state_sel),
    .br_taken  (br_taken),
    .ctrl      (ctrl),
    .mem_read  (mem_read),
    .mem_write (mem_write)
  );

  datapath datapath_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .mem_rdata   (mem_rdata),
    .instruction (instruction),
    .br_taken    (br_taken),
    .mem_req     (mem_req)
  );

endmodule

`default_nettype wire

// ==== source/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module datapath (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire mips_pkg::ctrl_t  ctrl,
  input  wire                   mem_read,
  input  wire                   mem_write,
  input  wire [`MIPS_XLEN-1:0]  mem_rdata,
  output logic [`MIPS_XLEN-1:0] instruction,
  output logic                  br_taken,
  output mips_pkg::mem_req_t    mem_req
);

  logic [`MIPS_XLEN-1:0] pc_q;
  logic [`MIPS_XLEN-1:0] ir_q;
  logic [`MIPS_XLEN-1:0] a_q;
  logic [`MIPS_XLEN-1:0] b_q;
  logic [`MIPS_XLEN-1:0] alu_out_q;
  logic [`MIPS_XLEN-1:0] mdr_q;
  logic [`MIPS_XLEN-1:0] rd1;
  logic [`MIPS_XLEN-1:0] rd2;
  logic [`MIPS_XLEN-1:0] imm_ext;
  logic [`MIPS_XLEN-1:0] alu_b;
  logic [`MIPS_XLEN-1:0] alu_y;
  logic [`MIPS_XLEN-1:0] br_target;
  logic [`MIPS_XLEN-1:0] ld_shift;
  logic [`MIPS_XLEN-1:0] load_data;
  logic [`MIPS_XLEN-1:0] st_data;
  logic [`MIPS_XLEN-1:0] wd;
  logic [3:0]            st_be;
  logic [4:0]            wa;
  logic [5:0]            opcode;
  logic                  alu_eq;

  assign opcode      = ir_q[31:26];
  assign instruction = ir_q;

  // ANDI, ORI, XORI, LUI zero-extend
  assign imm_ext = (opcode[5:2] == 4'b0011) ? {16'h0000, ir_q[15:0]}
                                            : {{16{ir_q[15]}}, ir_q[15:0]};
  assign alu_b     = ctrl.imm_sel ? imm_ext : b_q;
  assign br_target = pc_q + {imm_ext[`MIPS_XLEN-3:0], 2'b00};  // PC already +4
  assign br_taken  = alu_eq & ctrl.br_cmp;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pc_q <= `MIPS_RESET_PC;
    end
    else if (ctrl.pc_we)
    begin
      pc_q <= ctrl.br_cmp ? br_target : pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ctrl.ir_we)
    begin
      ir_q <= mem_rdata;
    end
    if (ctrl.ab_we)
    begin
      a_q <= rd1;
      b_q <= rd2;
    end
    if (ctrl.alu_we)
    begin
      alu_out_q <= alu_y;
    end
    if (ctrl.mdr_we)
    begin
      mdr_q <= mem_rdata;
    end
  end

  assign ld_shift = mdr_q >> {alu_out_q[1:0], 3'b000};

  always_comb
  begin
    case (opcode)
      6'b100000: load_data = {{24{ld_shift[7]}}, ld_shift[7:0]};    // LB
      6'b100100: load_data = {24'h000000, ld_shift[7:0]};           // LBU
      6'b100001: load_data = {{16{ld_shift[15]}}, ld_shift[15:0]};  // LH
      6'b100101: load_data = {16'h0000, ld_shift[15:0]};            // LHU
      default:   load_data = mdr_q;
    endcase
  end

  // Store lanes, little-endian
  always_comb
  begin
    case (opcode)
      6'b101000:
      begin
        st_data = {4{b_q[7:0]}};
        st_be   = 4'b0001 << alu_out_q[1:0];
      end
      6'b101001:
      begin
        st_data = {2{b_q[15:0]}};
        st_be   = alu_out_q[1] ? 4'b1100 : 4'b0011;
      end
      default:
      begin
        st_data = b_q;
        st_be   = 4'b1111;
      end
    endcase
  end

  assign wa = ctrl.dst_sel ? ir_q[15:11] : ir_q[20:16];
  assign wd = (opcode[5:3] == 3'b100) ? load_data : alu_out_q;

  always_comb
  begin
    mem_req.read  = mem_read;
    mem_req.write = mem_write;
    mem_req.wdata = st_data;
    mem_req.be    = mem_write ? st_be : 4'b1111;
    if (mem_write)
    begin
      mem_req.addr = alu_out_q;
    end
    else
    begin
      mem_req.addr = ctrl.alu_we ? alu_y : pc_q;  // Load address or fetch
    end
  end

  reg_file reg_file_i (
    .clk (clk),
    .ra1 (ir_q[25:21]),
    .ra2 (ir_q[20:16]),
    .wa  (wa),
    .we  (ctrl.reg_we),
    .wd  (wd),
    .rd1 (rd1),
    .rd2 (rd2)
  );

  alu alu_i (
    .a     (a_q),
    .b     (alu_b),
    .shamt (ir_q[10:6]),
    .op    (ctrl.alu_op),
    .y     (alu_y),
    .eq    (alu_eq)
  );

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module reg_file (
  input  wire                   clk,
  input  wire [4:0]             ra1,
  input  wire [4:0]             ra2,
  input  wire [4:0]             wa,
  input  wire                   we,
  input  wire [`MIPS_XLEN-1:0]  wd,
  output logic [`MIPS_XLEN-1:0] rd1,
  output logic [`MIPS_XLEN-1:0] rd2
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

  always_ff @(posedge clk)
  begin
    if (we && (wa != 5'd0))
    begin
      regs[wa] <= wd;
    end
  end

  // $zero reads back as constant
  assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module alu (
  input  wire [`MIPS_XLEN-1:0]  a,
  input  wire [`MIPS_XLEN-1:0]  b,
  input  wire [4:0]             shamt,
  input  wire mips_pkg::alu_op_t op,
  output logic [`MIPS_XLEN-1:0] y,
  output logic                  eq
);
  import mips_pkg::*;

  localparam int CW = $clog2(`MIPS_XLEN) + 1;

  logic [CW-1:0] lead_ones;
  logic [CW-1:0] lead_zeros;

  function automatic logic [CW-1:0] count_lead(
    input logic [`MIPS_XLEN-1:0] v,
    input logic                  bit_val
  );
    logic [CW-1:0] n;
    logic          run;
    n   = '0;
    run = 1'b1;
    for (int i = `MIPS_XLEN - 1; i >= 0; i--)
    begin
      run = run & (v[i] == bit_val);  // Stops at first differing bit
      n   = n + CW'(run);
    end
    return n;
  endfunction

  assign lead_ones  = count_lead(a, 1'b1);
  assign lead_zeros = count_lead(a, 1'b0);
  assign eq         = (a == b);

  always_comb
  begin
    case (op)
      alu_add:  y = a + b;
      alu_sub:  y = a - b;
      alu_sltu: y = {{(`MIPS_XLEN-1){1'b0}}, (a < b)};
      alu_and:  y = a & b;
      alu_or:   y = a | b;
      alu_xor:  y = a ^ b;
      alu_nor:  y = ~(a | b);
      alu_lui:  y = {b[15:0], 16'h0000};
      alu_sll:  y = b << shamt;
      alu_sra:  y = $signed(b) >>> shamt;
      alu_srl:  y = b >> shamt;
      alu_clo:  y = {{(`MIPS_XLEN-CW){1'b0}}, lead_ones};
      alu_clz:  y = {{(`MIPS_XLEN-CW){1'b0}}, lead_zeros};
      default:  y = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire mips_pkg::state_sel_t state_sel,
  input  wire                       br_taken,
  output mips_pkg::ctrl_t           ctrl,
  output logic                      mem_read,
  output logic                      mem_write
);
  import mips_pkg::*;

  state_sel_t state_q;
  state_sel_t state_d;
  logic       dst_rd_q;  // Writeback target remembered from execute
  alu_op_t    exec_op;
  logic       exec_imm;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= st_none;
      dst_rd_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (ctrl.alu_we)
      begin
        dst_rd_q <= ~ctrl.imm_sel;
      end
    end
  end

  // ALU operation and operand select per execute state
  always_comb
  begin
    exec_imm = 1'b0;
    case (state_q)
      st_subu:           exec_op = alu_sub;
      st_beq:            exec_op = alu_sub;
      st_sltu, st_sltiu: exec_op = alu_sltu;
      st_and, st_andi:   exec_op = alu_and;
      st_or, st_ori:     exec_op = alu_or;
      st_xor, st_xori:   exec_op = alu_xor;
      st_nor:            exec_op = alu_nor;
      st_lui:            exec_op = alu_lui;
      st_sll:            exec_op = alu_sll;
      st_sra:            exec_op = alu_sra;
      st_srl:            exec_op = alu_srl;
      st_clo:            exec_op = alu_clo;
      st_clz:            exec_op = alu_clz;
      default:           exec_op = alu_add;
    endcase
    case (state_q)
      st_addiu, st_sltiu, st_andi, st_ori, st_xori, st_lui, st_store, st_load:
      begin
        exec_imm = 1'b1;
      end
      default:
      begin
        exec_imm = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    ctrl         = '0;
    ctrl.alu_op  = exec_op;
    ctrl.imm_sel = exec_imm;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    state_d      = st_fetch;
    unique case (state_q)
      st_fetch:
      begin
        mem_read = 1'b1;
        state_d  = st_iwait;
      end
      st_iwait:
      begin
        ctrl.ir_we = 1'b1;
        ctrl.pc_we = 1'b1;  // PC+4
        state_d    = st_decode;
      end
      st_decode:
      begin
        ctrl.ab_we = 1'b1;
        state_d    = state_sel;
      end
      st_store:
      begin
        ctrl.alu_we = 1'b1;
        state_d     = st_store_write;
      end
      st_store_write:
      begin
        mem_write = 1'b1;
      end
      st_load:
      begin
        mem_read    = 1'b1;  // Address straight from the ALU
        ctrl.alu_we = 1'b1;
        state_d     = st_load_wait;
      end
      st_load_wait:
      begin
        ctrl.mdr_we = 1'b1;
        state_d     = st_load_wb;
      end
      st_load_wb, st_reg_wb:
      begin
        ctrl.reg_we  = 1'b1;
        ctrl.dst_sel = dst_rd_q;
      end
      st_beq:
      begin
        ctrl.br_cmp = 1'b1;
        ctrl.pc_we  = br_taken;
      end
      st_none:
      begin
        state_d = st_fetch;
      end
      default:
      begin
        ctrl.alu_we = 1'b1;  // Register and immediate ALU ops
        state_d     = st_reg_wb;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module instr_decoder (
  input  wire [`MIPS_XLEN-1:0] instruction,
  output mips_pkg::state_sel_t state_sel
);
  import mips_pkg::*;

  always_comb
  begin
    casez (instruction)
      32'b000000????????????????????100001: state_sel = st_addu;   // ADDU
      32'b000000????????????????????100011: state_sel = st_subu;   // SUBU
      32'b001001??????????????????????????: state_sel = st_addiu;  // ADDIU
      32'b000000????????????????????101011: state_sel = st_sltu;   // SLTU
      32'b001011??????????????????????????: state_sel = st_sltiu;  // SLTIU

      // SPECIAL2 leading counts
      32'b011100????????????????????100001: state_sel = st_clo;    // CLO
      32'b011100????????????????????100000: state_sel = st_clz;    // CLZ

      32'b000000????????????????????100100: state_sel = st_and;    // AND
      32'b001100??????????????????????????: state_sel = st_andi;   // ANDI
      32'b000000????????????????????100101: state_sel = st_or;     // OR
      32'b001101??????????????????????????: state_sel = st_ori;    // ORI
      32'b000000????????????????????100110: state_sel = st_xor;    // XOR
      32'b001110??????????????????????????: state_sel = st_xori;   // XORI
      32'b000000????????????????????100111: state_sel = st_nor;    // NOR
      32'b001111??????????????????????????: state_sel = st_lui;    // LUI

      32'b000000????????????????????000000: state_sel = st_sll;    // SLL, also NOP
      32'b000000????????????????????000011: state_sel = st_sra;    // SRA
      32'b000000????????????????????000010: state_sel = st_srl;    // SRL

      32'b101000??????????????????????????: state_sel = st_store;  // SB
      32'b101001??????????????????????????: state_sel = st_store;  // SH
      32'b101011??????????????????????????: state_sel = st_store;  // SW

      32'b000100??????????????????????????: state_sel = st_beq;    // BEQ

      32'b100011??????????????????????????: state_sel = st_load;   // LW
      32'b100001??????????????????????????: state_sel = st_load;   // LH
      32'b100101??????????????????????????: state_sel = st_load;   // LHU
      32'b100000??????????????????????????: state_sel = st_load;   // LB
      32'b100100??????????????????????????: state_sel = st_load;   // LBU

      default: state_sel = st_none;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/mips_pkg.sv ====
`default_nettype none

`include "mips_config.svh"

package mips_pkg;

  // Sequencer states, decoder entry points keep their fixed numbers
  typedef enum logic [6:0] {
    st_none        = 7'd0,  // Reset and illegal words
    st_fetch       = 7'd1,
    st_iwait       = 7'd2,
    st_decode      = 7'd3,
    st_reg_wb      = 7'd4,
    st_addu        = 7'd6,
    st_store       = 7'd7,
    st_store_write = 7'd8,
    st_beq         = 7'd11,
    st_load        = 7'd13,
    st_load_wait   = 7'd14,
    st_load_wb     = 7'd15,
    st_subu        = 7'd17,
    st_addiu       = 7'd18,
    st_sltu        = 7'd19,
    st_sltiu       = 7'd20,
    st_clo         = 7'd21,
    st_clz         = 7'd22,
    st_and         = 7'd23,
    st_andi        = 7'd24,
    st_or          = 7'd25,
    st_ori         = 7'd26,
    st_xor         = 7'd27,
    st_xori        = 7'd28,
    st_nor         = 7'd29,
    st_lui         = 7'd30,
    st_sll         = 7'd31,
    st_sra         = 7'd32,
    st_srl         = 7'd33
  } state_sel_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sltu,
    alu_and,
    alu_or,
    alu_xor,
    alu_nor,
    alu_lui,
    alu_sll,
    alu_sra,
    alu_srl,
    alu_clo,
    alu_clz
  } alu_op_t;

  typedef struct packed {
    logic    pc_we;
    logic    ir_we;
    logic    ab_we;
    logic    alu_we;
    logic    mdr_we;
    alu_op_t alu_op;
    logic    imm_sel;  // ALU b from immediate
    logic    br_cmp;
    logic    reg_we;
    logic    dst_sel;  // 1 selects rd, 0 selects rt
  } ctrl_t;

  typedef struct packed {
    logic                  read;
    logic                  write;
    logic [`MIPS_XLEN-1:0] addr;
    logic [`MIPS_XLEN-1:0] wdata;
    logic [3:0]            be;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== source/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Data path and address width
`define MIPS_XLEN 32

`define MIPS_NREGS 32

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif
